/* Makefile */
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= TEST OK

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/exec_units.sv */
`timescale 1ns/1ns

module exec_units (
  input  logic                                       clock,
  input  logic                                       reset,
  input  ooo_pkg::fu_data_t                          fu_data_i,
  input  logic                                       alu_valid_i,
  input  logic                                       mdu_valid_i,
  output logic                                       mdu_ready_o,
  output ooo_pkg::wb_t [ooo_pkg::WriteBackPorts-1:0] wb_o
);

  // multiplier bits consumed per cycle
  localparam int StepBits = 32 / ooo_pkg::MulCycles;
  localparam int CntWidth = $clog2(ooo_pkg::MulCycles);

  ooo_pkg::wb_t          alu_wb_q, mdu_wb_q;
  ooo_pkg::xlen_t        alu_result;
  logic                  mul_busy_q;
  logic [CntWidth-1:0]   mul_cnt_q;
  ooo_pkg::xlen_t        mul_a_q, mul_b_q, mul_acc_q;
  ooo_pkg::sb_idx_t      mul_idx_q;
  ooo_pkg::xlen_t        step_a, step_b, step_acc, step_sum;

  assign wb_o[0] = alu_wb_q;
  assign wb_o[1] = mdu_wb_q;

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------
  always_comb begin
    case (fu_data_i.op)
      ooo_pkg::ADD:      alu_result = fu_data_i.operand_a + fu_data_i.operand_b;
      ooo_pkg::SUB:      alu_result = fu_data_i.operand_a - fu_data_i.operand_b;
      ooo_pkg::AND:      alu_result = fu_data_i.operand_a & fu_data_i.operand_b;
      ooo_pkg::OR:       alu_result = fu_data_i.operand_a | fu_data_i.operand_b;
      ooo_pkg::XOR:      alu_result = fu_data_i.operand_a ^ fu_data_i.operand_b;
      ooo_pkg::SLT: begin
        alu_result = {31'b0, $signed(fu_data_i.operand_a) < $signed(fu_data_i.operand_b)};
      end
      ooo_pkg::SLL:      alu_result = fu_data_i.operand_a << fu_data_i.operand_b[4:0];
      ooo_pkg::SRL:      alu_result = fu_data_i.operand_a >> fu_data_i.operand_b[4:0];
      ooo_pkg::LUI_PASS: alu_result = fu_data_i.operand_b;
      default:           alu_result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_wb_q.valid <= 1'b0;
    end else begin
      alu_wb_q.valid <= alu_valid_i;
    end
    if (alu_valid_i) begin
      alu_wb_q.idx  <= fu_data_i.idx;
      alu_wb_q.data <= alu_result;
    end
  end

  // ----------------------------------------------------------------------
  // iterative multiplier
  // ----------------------------------------------------------------------
  function automatic ooo_pkg::xlen_t shift_add(ooo_pkg::xlen_t acc, ooo_pkg::xlen_t a,
                                               logic [StepBits-1:0] bits);
    ooo_pkg::xlen_t sum;
    sum = acc;
    for (int i = 0; i < StepBits; i++) begin
      if (bits[i]) begin
        sum = sum + (a << i);
      end
    end
    return sum;
  endfunction

  // first step runs straight off the issued operands
  assign step_a   = mdu_valid_i ? fu_data_i.operand_a : mul_a_q;
  assign step_b   = mdu_valid_i ? fu_data_i.operand_b : mul_b_q;
  assign step_acc = mdu_valid_i ? '0 : mul_acc_q;
  assign step_sum = shift_add(step_acc, step_a, step_b[StepBits-1:0]);

  assign mdu_ready_o = !mul_busy_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      mul_busy_q     <= 1'b0;
      mul_cnt_q      <= '0;
      mdu_wb_q.valid <= 1'b0;
    end else begin
      mdu_wb_q.valid <= 1'b0;
      if (mdu_valid_i) begin
        mul_busy_q <= 1'b1;
        mul_cnt_q  <= CntWidth'(ooo_pkg::MulCycles - 1);
      end else if (mul_busy_q) begin
        mul_cnt_q <= mul_cnt_q - 1'b1;
        if (mul_cnt_q == CntWidth'(1)) begin
          mul_busy_q     <= 1'b0;
          mdu_wb_q.valid <= 1'b1;
        end
      end
    end
    if (mdu_valid_i || mul_busy_q) begin
      mul_a_q   <= step_a << StepBits;
      mul_b_q   <= step_b >> StepBits;
      mul_acc_q <= step_sum;
    end
    if (mdu_valid_i) begin
      mul_idx_q <= fu_data_i.idx;
    end
    // low word of the product
    if (mul_busy_q && mul_cnt_q == CntWidth'(1)) begin
      mdu_wb_q.idx  <= mul_idx_q;
      mdu_wb_q.data <= step_sum;
    end
  end

endmodule

/* design/gpr_regfile.sv */
`timescale 1ns/1ns

module gpr_regfile (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::reg_addr_t raddr_1_i,
  input  ooo_pkg::reg_addr_t raddr_2_i,
  input  ooo_pkg::reg_addr_t waddr_i,
  input  ooo_pkg::xlen_t     wdata_i,
  input  logic               we_i,
  output ooo_pkg::xlen_t     rdata_1_o,
  output ooo_pkg::xlen_t     rdata_2_o
);

  ooo_pkg::xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rdata_1_o = (raddr_1_i == '0) ? '0 : regs[raddr_1_i];
  assign rdata_2_o = (raddr_2_i == '0) ? '0 : regs[raddr_2_i];

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
  input  logic              clock,
  input  logic              reset,
  input  ooo_pkg::xlen_t    instr_i,
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  output ooo_pkg::decoder_t dec_o,
  output logic              dec_valid_o,
  input  logic              dec_ready_i
);

  ooo_pkg::decoder_t dec_n;
  logic [9:0]        funct;

  // funct7 and funct3 side by side
  assign funct = {instr_i[31:25], instr_i[14:12]};

  always_comb begin : decode
    dec_n     = '0;
    dec_n.fu  = ooo_pkg::FU_ALU;
    dec_n.op  = ooo_pkg::ADD;
    dec_n.rd  = instr_i[11:7];
    dec_n.rs1 = instr_i[19:15];
    case (instr_i[6:0])
      ooo_pkg::OpcodeOp: begin
        dec_n.rs2 = instr_i[24:20];
        case (funct)
          10'b0000000_000: dec_n.op = ooo_pkg::ADD;
          10'b0100000_000: dec_n.op = ooo_pkg::SUB;
          10'b0000000_001: dec_n.op = ooo_pkg::SLL;
          10'b0000000_010: dec_n.op = ooo_pkg::SLT;
          10'b0000000_100: dec_n.op = ooo_pkg::XOR;
          10'b0000000_101: dec_n.op = ooo_pkg::SRL;
          10'b0000000_110: dec_n.op = ooo_pkg::OR;
          10'b0000000_111: dec_n.op = ooo_pkg::AND;
          10'b0000001_000: begin
            dec_n.op = ooo_pkg::MUL;
            dec_n.fu = ooo_pkg::FU_MDU;
          end
          default: dec_n.illegal = 1'b1;
        endcase
      end
      ooo_pkg::OpcodeOpImm: begin
        dec_n.use_imm = 1'b1;
        // sign-extended I immediate
        dec_n.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        case (instr_i[14:12])
          3'b000:  dec_n.op = ooo_pkg::ADD;
          3'b010:  dec_n.op = ooo_pkg::SLT;
          3'b100:  dec_n.op = ooo_pkg::XOR;
          3'b110:  dec_n.op = ooo_pkg::OR;
          3'b111:  dec_n.op = ooo_pkg::AND;
          default: dec_n.illegal = 1'b1;
        endcase
      end
      ooo_pkg::OpcodeLui: begin
        dec_n.rs1     = '0;
        dec_n.use_imm = 1'b1;
        dec_n.imm     = {instr_i[31:12], 12'b0};
        dec_n.op      = ooo_pkg::LUI_PASS;
      end
      default: dec_n.illegal = 1'b1;
    endcase

    // illegal words become no-write entries
    if (dec_n.illegal) begin
      dec_n.rs1     = '0;
      dec_n.rs2     = '0;
      dec_n.rd      = '0;
      dec_n.fu      = ooo_pkg::FU_NONE;
      dec_n.use_imm = 1'b0;
    end
  end

  // one-entry output register
  assign instr_ready_o = !dec_valid_o || dec_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid_o <= 1'b0;
    end else if (instr_valid_i && instr_ready_o) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
    if (instr_valid_i && instr_ready_o) begin
      dec_o <= dec_n;
    end
  end

endmodule

/* design/issue_stage.sv */
`timescale 1ns/1ns

module issue_stage #(
  parameter int ScoreboardDepth = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::decoder_t  dec_i,
  input  logic               dec_valid_i,
  output logic               dec_ready_o,
  scoreboard_if.iss_mp       sb,
  output ooo_pkg::fu_data_t  fu_data_o,
  output logic               alu_valid_o,
  output logic               mdu_valid_o,
  input  logic               mdu_ready_i,
  input  ooo_pkg::reg_addr_t gpr_waddr_i,
  input  ooo_pkg::xlen_t     gpr_wdata_i,
  input  logic               gpr_we_i
);

  ooo_pkg::fu_e      rd_clobber_fu  [32];
  ooo_pkg::sb_idx_t  rd_clobber_idx [32];
  ooo_pkg::reg_addr_t [1:0] src_addr;
  logic [1:0]               src_raw;
  logic [1:0]               src_fwd;
  ooo_pkg::xlen_t [1:0]     src_data;
  ooo_pkg::xlen_t           gpr_rdata_1, gpr_rdata_2;
  logic                     stall_raw, stall_waw;
  logic                     units_busy, fu_busy;
  ooo_pkg::fu_data_t        fu_data_n;

  gpr_regfile u_gpr_regfile (
    .clock     (clock),
    .reset     (reset),
    .raddr_1_i (dec_i.rs1),
    .raddr_2_i (dec_i.rs2),
    .waddr_i   (gpr_waddr_i),
    .wdata_i   (gpr_wdata_i),
    .we_i      (gpr_we_i),
    .rdata_1_o (gpr_rdata_1),
    .rdata_2_o (gpr_rdata_2)
  );

  // ----------------------------------------------------------------------
  // clobber table
  // ----------------------------------------------------------------------
  // walk slots oldest to newest starting at the tail, newest writer wins
  always_comb begin : clobber_table
    int unsigned slot;
    for (int r = 0; r < 32; r++) begin
      rd_clobber_fu[r]  = ooo_pkg::FU_NONE;
      rd_clobber_idx[r] = '0;
    end
    for (int unsigned k = 0; k < ScoreboardDepth; k++) begin
      slot = (k + sb.alloc_idx) % ScoreboardDepth;
      if (sb.issued[slot]) begin
        rd_clobber_fu[sb.entries[slot].rd]  = sb.entries[slot].fu;
        rd_clobber_idx[sb.entries[slot].rd] = ooo_pkg::sb_idx_t'(slot);
      end
    end
    rd_clobber_fu[0] = ooo_pkg::FU_NONE;
  end

  // ----------------------------------------------------------------------
  // operand forwarding
  // ----------------------------------------------------------------------
  assign src_addr = {dec_i.rs2, dec_i.rs1};

  always_comb begin : forwarding
    ooo_pkg::sb_idx_t idx;
    for (int s = 0; s < 2; s++) begin
      idx         = rd_clobber_idx[src_addr[s]];
      src_raw[s]  = rd_clobber_fu[src_addr[s]] != ooo_pkg::FU_NONE;
      src_fwd[s]  = sb.entries[idx].valid;
      src_data[s] = sb.entries[idx].result;
      // write-back ports beat entries, port 0 first
      for (int p = ooo_pkg::WriteBackPorts - 1; p >= 0; p--) begin
        if (sb.wb[p].valid && sb.wb[p].idx == idx) begin
          src_fwd[s]  = 1'b1;
          src_data[s] = sb.wb[p].data;
        end
      end
    end
  end

  assign stall_raw = (src_raw[0] && !src_fwd[0]) || (src_raw[1] && !src_fwd[1]);

  // WAW is fine if commit writes that rd this cycle
  assign stall_waw = (rd_clobber_fu[dec_i.rd] != ooo_pkg::FU_NONE) &&
                     !(gpr_we_i && gpr_waddr_i == dec_i.rd);

  // ----------------------------------------------------------------------
  // unit busy and issue decision
  // ----------------------------------------------------------------------
  // a running multiply blocks both units
  assign units_busy = !mdu_ready_i || mdu_valid_o;

  always_comb begin
    case (dec_i.fu)
      ooo_pkg::FU_ALU, ooo_pkg::FU_MDU: fu_busy = units_busy;
      default:                          fu_busy = 1'b0;
    endcase
  end

  assign dec_ready_o = dec_valid_i && !fu_busy && !sb.full && !stall_raw && !stall_waw;

  assign sb.issue_fire    = dec_ready_o;
  assign sb.issue_rd      = dec_i.rd;
  assign sb.issue_fu      = dec_i.fu;
  assign sb.issue_illegal = dec_i.illegal;

  // operand mux
  always_comb begin
    fu_data_n.operand_a = src_raw[0] ? src_data[0] : gpr_rdata_1;
    fu_data_n.operand_b = src_raw[1] ? src_data[1] : gpr_rdata_2;
    if (dec_i.use_imm) begin
      fu_data_n.operand_b = dec_i.imm;
    end
    fu_data_n.op  = dec_i.op;
    fu_data_n.idx = sb.alloc_idx;
  end

  // issue register
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_valid_o <= 1'b0;
      mdu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= dec_ready_o && dec_i.fu == ooo_pkg::FU_ALU;
      mdu_valid_o <= dec_ready_o && dec_i.fu == ooo_pkg::FU_MDU;
    end
    fu_data_o <= fu_data_n;
  end

endmodule

/* design/ooo_core.sv */
`timescale 1ns/1ns

module ooo_core #(
  parameter int ScoreboardDepth = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::xlen_t     instr_i,
  input  logic               instr_valid_i,
  output logic               instr_ready_o,
  output logic               commit_valid_o,
  output ooo_pkg::reg_addr_t commit_rd_o,
  output ooo_pkg::xlen_t     commit_data_o,
  output logic               commit_illegal_o
);

  ooo_pkg::decoder_t dec;
  logic              dec_valid, dec_ready;
  ooo_pkg::fu_data_t fu_data;
  logic              alu_valid, mdu_valid, mdu_ready;

  scoreboard_if #(.ScoreboardDepth(ScoreboardDepth)) sb_bus ();

  instr_decoder u_instr_decoder (
    .clock         (clock),
    .reset         (reset),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .dec_o         (dec),
    .dec_valid_o   (dec_valid),
    .dec_ready_i   (dec_ready)
  );

  // commit drives the register file write
  issue_stage #(.ScoreboardDepth(ScoreboardDepth)) u_issue_stage (
    .clock       (clock),
    .reset       (reset),
    .dec_i       (dec),
    .dec_valid_i (dec_valid),
    .dec_ready_o (dec_ready),
    .sb          (sb_bus.iss_mp),
    .fu_data_o   (fu_data),
    .alu_valid_o (alu_valid),
    .mdu_valid_o (mdu_valid),
    .mdu_ready_i (mdu_ready),
    .gpr_waddr_i (commit_rd_o),
    .gpr_wdata_i (commit_data_o),
    .gpr_we_i    (commit_valid_o)
  );

  exec_units u_exec_units (
    .clock       (clock),
    .reset       (reset),
    .fu_data_i   (fu_data),
    .alu_valid_i (alu_valid),
    .mdu_valid_i (mdu_valid),
    .mdu_ready_o (mdu_ready),
    .wb_o        (sb_bus.wb)
  );

  scoreboard #(.ScoreboardDepth(ScoreboardDepth)) u_scoreboard (
    .clock            (clock),
    .reset            (reset),
    .sb               (sb_bus.sb_mp),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_illegal_o (commit_illegal_o)
  );

endmodule

/* design/ooo_pkg.sv */
package ooo_pkg;

  // ----------------------------------------------------------------------
  // widths fixed by the ISA
  // ----------------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // upper bound on the scoreboard depth, sizes the slot index
  localparam int MaxSbDepth = 4;
  typedef logic [$clog2(MaxSbDepth)-1:0] sb_idx_t;

  // write-back ports: ALU on 0, MDU on 1
  localparam int WriteBackPorts = 2;
  localparam int MulCycles      = 4;

  // major opcodes
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;
  localparam logic [6:0] OpcodeLui   = 7'b0110111;

  typedef enum logic [1:0] {FU_NONE, FU_ALU, FU_MDU} fu_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, LUI_PASS, MUL
  } alu_op_e;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    fu_e       fu;
    alu_op_e   op;
    logic      use_imm;
    xlen_t     imm;
    logic      illegal;
  } decoder_t;

  typedef struct packed {
    xlen_t   operand_a;
    xlen_t   operand_b;
    alu_op_e op;
    sb_idx_t idx;
  } fu_data_t;

  typedef struct packed {
    logic    valid;
    sb_idx_t idx;
    xlen_t   data;
  } wb_t;

  typedef struct packed {
    reg_addr_t rd;
    fu_e       fu;
    logic      valid;
    logic      illegal;
    xlen_t     result;
  } sb_entry_t;

endpackage

/* design/scoreboard.sv */
`timescale 1ns/1ns

module scoreboard #(
  parameter int ScoreboardDepth = 4
) (
  input  logic               clock,
  input  logic               reset,
  scoreboard_if.sb_mp        sb,
  output logic               commit_valid_o,
  output ooo_pkg::reg_addr_t commit_rd_o,
  output ooo_pkg::xlen_t     commit_data_o,
  output logic               commit_illegal_o
);

  localparam int CountWidth = $clog2(ScoreboardDepth + 1);

  ooo_pkg::sb_entry_t [ScoreboardDepth-1:0] entries_q;
  logic [ScoreboardDepth-1:0]               issued_q;
  ooo_pkg::sb_idx_t                         head_q, tail_q, commit_idx_q;
  logic [CountWidth-1:0]                    count_q;
  ooo_pkg::sb_entry_t                       head_entry;
  ooo_pkg::xlen_t                           head_data;
  logic                                     head_wb_hit, head_done;

  function automatic ooo_pkg::sb_idx_t next_idx(ooo_pkg::sb_idx_t idx);
    if (idx == ooo_pkg::sb_idx_t'(ScoreboardDepth - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  assign sb.issued    = issued_q;
  assign sb.entries   = entries_q;
  assign sb.alloc_idx = tail_q;
  assign sb.full      = count_q == CountWidth'(ScoreboardDepth);

  // head can commit on the cycle its write-back arrives
  always_comb begin
    head_entry  = entries_q[head_q];
    head_data   = head_entry.result;
    head_wb_hit = 1'b0;
    for (int p = 0; p < ooo_pkg::WriteBackPorts; p++) begin
      if (sb.wb[p].valid && sb.wb[p].idx == head_q) begin
        head_wb_hit = 1'b1;
        head_data   = sb.wb[p].data;
      end
    end
    head_done = issued_q[head_q] && (head_entry.valid || head_wb_hit);
  end

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------
  // a committed slot stays occupied until its register write is done
  always_ff @(posedge clock) begin
    if (reset) begin
      issued_q       <= '0;
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      commit_valid_o <= 1'b0;
    end else begin
      if (commit_valid_o) begin
        issued_q[commit_idx_q] <= 1'b0;
      end
      if (sb.issue_fire) begin
        issued_q[tail_q] <= 1'b1;
        tail_q           <= next_idx(tail_q);
      end
      count_q <= count_q + CountWidth'(sb.issue_fire) - CountWidth'(commit_valid_o);
      commit_valid_o <= head_done;
      if (head_done) begin
        head_q <= next_idx(head_q);
      end
    end
  end

  // ----------------------------------------------------------------------
  // entry payload and commit register
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    for (int p = 0; p < ooo_pkg::WriteBackPorts; p++) begin
      if (sb.wb[p].valid) begin
        entries_q[sb.wb[p].idx].valid  <= 1'b1;
        entries_q[sb.wb[p].idx].result <= sb.wb[p].data;
      end
    end
    if (sb.issue_fire) begin
      entries_q[tail_q] <= '{
        rd:      sb.issue_rd,
        fu:      sb.issue_fu,
        valid:   sb.issue_illegal || sb.issue_fu == ooo_pkg::FU_NONE,
        illegal: sb.issue_illegal,
        result:  '0
      };
    end
    if (head_done) begin
      commit_idx_q     <= head_q;
      commit_rd_o      <= head_entry.illegal ? '0 : head_entry.rd;
      commit_data_o    <= head_data;
      commit_illegal_o <= head_entry.illegal;
    end
  end

endmodule

/* design/scoreboard_if.sv */
`timescale 1ns/1ns

interface scoreboard_if #(
  parameter int ScoreboardDepth = 4
);

  // scoreboard state seen by the issue stage
  logic [ScoreboardDepth-1:0]                    issued;
  ooo_pkg::sb_entry_t [ScoreboardDepth-1:0]      entries;
  ooo_pkg::sb_idx_t                              alloc_idx;
  logic                                          full;

  // write-back ports, driven by the execute units
  ooo_pkg::wb_t [ooo_pkg::WriteBackPorts-1:0]    wb;

  // new entry from the issue stage
  logic                                          issue_fire;
  ooo_pkg::reg_addr_t                            issue_rd;
  ooo_pkg::fu_e                                  issue_fu;
  logic                                          issue_illegal;

  modport sb_mp (
    output issued, entries, alloc_idx, full,
    input  wb, issue_fire, issue_rd, issue_fu, issue_illegal
  );

  modport iss_mp (
    input  issued, entries, alloc_idx, full, wb,
    output issue_fire, issue_rd, issue_fu, issue_illegal
  );

endinterface

/* dv/ooo_core_tb.sv */
`timescale 1ns/1ns

module ooo_core_tb;

  localparam int SbDepth       = 4;
  localparam int MaxRows       = 64;
  localparam int ReadyTimeout  = 200;
  localparam int CommitTimeout = 200;
  localparam int DrainCycles   = 20;

  // RV32 opcodes and function fields
  localparam logic [6:0] OpReg  = 7'b0110011;
  localparam logic [6:0] OpImm  = 7'b0010011;
  localparam logic [6:0] OpLui  = 7'b0110111;
  localparam logic [6:0] F7Base = 7'b0000000;
  localparam logic [6:0] F7Alt  = 7'b0100000;
  localparam logic [6:0] F7Mul  = 7'b0000001;
  localparam logic [2:0] F3Add  = 3'b000;
  localparam logic [2:0] F3Sll  = 3'b001;
  localparam logic [2:0] F3Slt  = 3'b010;
  localparam logic [2:0] F3Xor  = 3'b100;
  localparam logic [2:0] F3Srl  = 3'b101;
  localparam logic [2:0] F3Or   = 3'b110;
  localparam logic [2:0] F3And  = 3'b111;

  logic        clock;
  logic        reset;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic        commit_valid_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;
  logic        commit_illegal_o;

  // stimulus table, one row per instruction in program order
  logic [31:0] row_instr   [MaxRows];
  logic [4:0]  row_rd      [MaxRows];
  logic [31:0] row_data    [MaxRows];
  logic        row_illegal [MaxRows];
  int          num_rows;
  int          burst_first;
  int          burst_last;
  logic        full_stall;
  logic [31:0] rng_state;
  int          errors;
  int          commits;
  logic        abort;

  ooo_core #(.ScoreboardDepth(SbDepth)) dut (
    .clock            (clock),
    .reset            (reset),
    .instr_i          (instr_i),
    .instr_valid_i    (instr_valid_i),
    .instr_ready_o    (instr_ready_o),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_illegal_o (commit_illegal_o)
  );

  always #10 clock = ~clock;

  // ----------------------------------------------------------------------
  // instruction encoding and table
  // ----------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OpReg};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd,
                                         input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), OpImm};
  endfunction

  function automatic logic [31:0] u_type(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), OpLui};
  endfunction

  // xorshift32 for idle gaps
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic add_row(input logic [31:0] instr, input int rd, input logic [31:0] data,
                         input logic illegal);
    row_instr[num_rows]   = instr;
    row_rd[num_rows]      = 5'(rd);
    row_data[num_rows]    = data;
    row_illegal[num_rows] = illegal;
    num_rows++;
  endtask

  task automatic build_table();
    // independent ALU and immediate ops
    add_row(i_type(F3Add, 1, 0, 100), 1, 32'h0000_0064, 1'b0);
    add_row(i_type(F3Add, 2, 0, -7), 2, 32'hFFFF_FFF9, 1'b0);
    add_row(r_type(F7Base, F3Add, 3, 1, 2), 3, 32'h0000_005D, 1'b0);
    add_row(r_type(F7Alt, F3Add, 4, 1, 2), 4, 32'h0000_006B, 1'b0);
    add_row(r_type(F7Base, F3Slt, 5, 2, 1), 5, 32'h0000_0001, 1'b0);
    add_row(r_type(F7Base, F3Slt, 6, 1, 2), 6, 32'h0000_0000, 1'b0);
    add_row(i_type(F3Slt, 7, 2, -1), 7, 32'h0000_0001, 1'b0);
    add_row(r_type(F7Base, F3And, 8, 1, 2), 8, 32'h0000_0060, 1'b0);
    add_row(r_type(F7Base, F3Or, 9, 1, 2), 9, 32'hFFFF_FFFD, 1'b0);
    add_row(r_type(F7Base, F3Xor, 10, 1, 2), 10, 32'hFFFF_FF9D, 1'b0);
    add_row(i_type(F3Add, 11, 0, 4), 11, 32'h0000_0004, 1'b0);
    add_row(r_type(F7Base, F3Sll, 12, 1, 11), 12, 32'h0000_0640, 1'b0);
    add_row(r_type(F7Base, F3Srl, 13, 2, 11), 13, 32'h0FFF_FFFF, 1'b0);
    add_row(u_type(14, 32'h12345), 14, 32'h1234_5000, 1'b0);
    add_row(i_type(F3Or, 15, 14, 32'h678), 15, 32'h1234_5678, 1'b0);
    add_row(i_type(F3Xor, 16, 15, -1), 16, 32'hEDCB_A987, 1'b0);
    add_row(i_type(F3And, 17, 16, 32'hFF), 17, 32'h0000_0087, 1'b0);
    // back-to-back RAW chain on x20
    add_row(i_type(F3Add, 20, 0, 1), 20, 32'h0000_0001, 1'b0);
    add_row(i_type(F3Add, 20, 20, 2), 20, 32'h0000_0003, 1'b0);
    add_row(i_type(F3Add, 20, 20, 3), 20, 32'h0000_0006, 1'b0);
    add_row(i_type(F3Add, 20, 20, 4), 20, 32'h0000_000A, 1'b0);
    add_row(r_type(F7Base, F3Add, 21, 20, 20), 21, 32'h0000_0014, 1'b0);
    // multiply with dependent and independent followers
    add_row(i_type(F3Add, 22, 0, 1234), 22, 32'h0000_04D2, 1'b0);
    add_row(i_type(F3Add, 23, 0, -3), 23, 32'hFFFF_FFFD, 1'b0);
    add_row(r_type(F7Mul, F3Add, 24, 22, 23), 24, 32'hFFFF_F18A, 1'b0);
    add_row(r_type(F7Base, F3Add, 25, 24, 1), 25, 32'hFFFF_F1EE, 1'b0);
    add_row(i_type(F3Add, 26, 0, 55), 26, 32'h0000_0037, 1'b0);
    add_row(r_type(F7Base, F3Add, 27, 25, 24), 27, 32'hFFFF_E378, 1'b0);
    add_row(r_type(F7Base, F3Xor, 28, 26, 1), 28, 32'h0000_0053, 1'b0);
    add_row(r_type(F7Mul, F3Add, 29, 15, 15), 29, 32'h1DF4_D840, 1'b0);
    // two writers of x30, reader must see the second
    add_row(r_type(F7Mul, F3Add, 30, 1, 11), 30, 32'h0000_0190, 1'b0);
    add_row(i_type(F3Add, 30, 0, 9), 30, 32'h0000_0009, 1'b0);
    add_row(r_type(F7Base, F3Add, 31, 30, 1), 31, 32'h0000_006D, 1'b0);
    // multiply burst deeper than the scoreboard, then illegal words
    // that need no unit and pile up behind the last multiply
    burst_first = num_rows;
    add_row(r_type(F7Mul, F3Add, 5, 1, 1), 5, 32'h0000_2710, 1'b0);
    add_row(r_type(F7Mul, F3Add, 6, 2, 2), 6, 32'h0000_0031, 1'b0);
    add_row(r_type(F7Mul, F3Add, 7, 1, 2), 7, 32'hFFFF_FD44, 1'b0);
    add_row(r_type(F7Mul, F3Add, 8, 11, 11), 8, 32'h0000_0010, 1'b0);
    add_row(r_type(F7Mul, F3Add, 9, 22, 1), 9, 32'h0001_E208, 1'b0);
    add_row(r_type(F7Mul, F3Add, 10, 20, 20), 10, 32'h0000_0064, 1'b0);
    add_row(32'hFFFF_FFFF, 0, 32'h0, 1'b1);
    add_row(r_type(F7Alt, F3Srl, 3, 1, 2), 0, 32'h0, 1'b1);
    add_row(i_type(F3Sll, 4, 1, 3), 0, 32'h0, 1'b1);
    add_row(32'h0000_2083, 0, 32'h0, 1'b1);
    burst_last = num_rows - 1;
    // x0 as a destination and a source
    add_row(i_type(F3Add, 0, 0, 123), 0, 32'h0, 1'b0);
    add_row(r_type(F7Base, F3Add, 12, 0, 1), 12, 32'h0000_0064, 1'b0);
    add_row(r_type(F7Base, F3Or, 13, 0, 0), 13, 32'h0000_0000, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // stimulus and commit checking
  // ----------------------------------------------------------------------
  task automatic drive_stimulus();
    int   gap;
    int   waited;
    logic accepted;
    for (int i = 0; i < num_rows && !abort; i++) begin
      gap = int'(next_random() % 3);
      // the burst runs back to back so that it can fill the scoreboard
      if (i >= burst_first && i <= burst_last) begin
        gap = 0;
      end
      if (gap != 0) begin
        instr_valid_i <= 1'b0;
        repeat (gap) @(posedge clock);
      end
      instr_i       <= row_instr[i];
      instr_valid_i <= 1'b1;
      waited   = 0;
      accepted = 1'b0;
      // ready seen at the falling edge means the next rising edge transfers
      while (!accepted && !abort) begin
        @(negedge clock);
        accepted = instr_ready_o;
        if (!accepted) begin
          // an illegal word in the decoder needs no unit, only a free slot
          if (i > 0 && row_illegal[i-1]) begin
            full_stall = 1'b1;
          end
          waited++;
          if (waited > ReadyTimeout) begin
            $display("timeout: instr_ready_o stayed low while offering row %0d", i);
            errors++;
            abort = 1'b1;
          end
        end
        @(posedge clock);
      end
    end
    instr_valid_i <= 1'b0;
  endtask

  task automatic compare_commit(input int i);
    commits++;
    if (commit_illegal_o !== row_illegal[i]) begin
      errors++;
      $display("error: row %0d commit_illegal_o = 0x%h, expected 0x%h",
               i, commit_illegal_o, row_illegal[i]);
    end
    if (commit_rd_o !== row_rd[i]) begin
      errors++;
      $display("error: row %0d commit_rd_o = 0x%h, expected 0x%h", i, commit_rd_o, row_rd[i]);
    end
    // x0 and illegal entries hold no architectural value
    if (row_rd[i] != 5'd0 && commit_data_o !== row_data[i]) begin
      errors++;
      $display("error: row %0d commit_data_o = 0x%h, expected 0x%h",
               i, commit_data_o, row_data[i]);
    end
  endtask

  task automatic check_commits();
    int waited;
    for (int i = 0; i < num_rows && !abort; i++) begin
      waited = 0;
      @(negedge clock);
      while (!commit_valid_o && !abort) begin
        waited++;
        if (waited > CommitTimeout) begin
          $display("timeout: no commit arrived for row %0d", i);
          errors++;
          abort = 1'b1;
        end else begin
          @(negedge clock);
        end
      end
      if (!abort) begin
        compare_commit(i);
      end
    end
  endtask

  // nothing may commit once the table is used up
  task automatic watch_extra_commits();
    repeat (DrainCycles) begin
      @(negedge clock);
      if (commit_valid_o) begin
        errors++;
        $display("an extra commit to rd %0d appeared after the last table row", commit_rd_o);
      end
    end
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    rng_state     = 32'd11001;
    errors        = 0;
    commits       = 0;
    abort         = 1'b0;
    full_stall    = 1'b0;
    num_rows      = 0;
    build_table();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    if (commit_valid_o !== 1'b0) begin
      errors++;
      $display("error: commit_valid_o = 0x%h after reset, expected 0x0", commit_valid_o);
    end
    if (instr_ready_o !== 1'b1) begin
      errors++;
      $display("error: instr_ready_o = 0x%h after reset, expected 0x1", instr_ready_o);
    end
    @(posedge clock);
    fork
      drive_stimulus();
      check_commits();
    join
    if (!abort) begin
      watch_extra_commits();
      if (!full_stall) begin
        errors++;
        $display("instr_ready_o never dropped behind a full scoreboard");
      end
    end
    $display("commits checked: %0d of %0d, errors: %0d", commits, num_rows, errors);
    if (errors == 0 && !abort) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
design/ooo_pkg.sv
design/scoreboard_if.sv
design/instr_decoder.sv
design/gpr_regfile.sv
design/issue_stage.sv
design/exec_units.sv
design/scoreboard.sv
design/ooo_core.sv
dv/ooo_core_tb.sv
